//--- source/rtc_pkg.sv
package rtc_pkg;

	typedef logic [31:0] rtc_word_t;
	typedef logic [21:0] tod_t;
	typedef logic [23:0] tmr_count_t;
	typedef logic [31:0] speed_t;
	typedef logic [4:0]  reg_sel_t;

	// Word index of each register, also its bit in reg_sel_t
	localparam int RTC_REG_CLOCK     = 0;
	localparam int RTC_REG_TIMER     = 1;
	localparam int RTC_REG_STOPWATCH = 2;
	localparam int RTC_REG_ALARM     = 3;
	localparam int RTC_REG_SPEED     = 4;
	localparam int RTC_NUM_REGS      = 5;

	localparam int TMR_RUN_BIT   = 24;
	localparam int TMR_ALARM_BIT = 25;
	localparam int AL_EN_BIT     = 24;
	localparam int AL_ACK_BIT    = 25;
	localparam int SW_RUN_BIT    = 0;
	localparam int SW_CLR_BIT    = 1;

	// One BCD step up, back to zero once lim is reached
	function automatic logic [7:0] bcd_inc(logic [7:0] v, logic [7:0] lim);
		if (v >= lim)
			return 8'h00;
		else if (v[3:0] >= 4'h9)
			return {v[7:4] + 4'h1, 4'h0};
		else
			return v + 8'h01;
	endfunction

	// All-ones fields keep the old value
	function automatic tod_t tod_merge(tod_t cur, rtc_word_t wr);
		tod_t r;
		r = cur;
		if (wr[21:16] != 6'h3f)
			r[21:16] = wr[21:16];
		if (wr[15:8] != 8'hff)
			r[15:8] = wr[15:8];
		if (wr[7:0] != 8'hff)
			r[7:0] = wr[7:0];
		return r;
	endfunction

endpackage

//--- source/rtc_reg_if.sv
`timescale 1ns/1ps

interface rtc_reg_if;
	import rtc_pkg::*;

	reg_sel_t  wr_sel;
	rtc_word_t wr_data;
	rtc_word_t clock_rd;
	rtc_word_t timer_rd;
	rtc_word_t sw_rd;
	rtc_word_t alarm_rd;
	rtc_word_t speed_rd;

	modport host (
		output wr_sel,
		output wr_data,
		input  clock_rd,
		input  timer_rd,
		input  sw_rd,
		input  alarm_rd,
		input  speed_rd
	);

	modport clock_mp (input wr_sel, input wr_data, output clock_rd);
	modport timer_mp (input wr_sel, input wr_data, output timer_rd);
	modport sw_mp    (input wr_sel, input wr_data, output sw_rd);
	modport alarm_mp (input wr_sel, input wr_data, output alarm_rd);
	modport speed_mp (input wr_sel, input wr_data, output speed_rd);

endinterface

//--- source/rtc_apb_slave.sv
`timescale 1ns/1ps

module rtc_apb_slave (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_psel,
	input  logic               i_penable,
	input  logic               i_pwrite,
	input  logic [4:0]         i_paddr,
	input  rtc_pkg::rtc_word_t i_pwdata,
	output rtc_pkg::rtc_word_t o_prdata,
	output logic               o_pready,
	output logic               o_pslverr,
	rtc_reg_if.host            bus,
	input  logic               i_tmr_int,
	input  logic               i_al_int,
	output logic               o_interrupt
);
	import rtc_pkg::*;

	logic [2:0] word_idx;
	logic       access;
	logic       bad_addr;

	assign word_idx  = i_paddr[4:2];
	assign access    = i_psel && i_penable;
	assign bad_addr  = (word_idx >= 3'(RTC_NUM_REGS));
	assign o_pready  = access;
	assign o_pslverr = access && bad_addr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write strobes, one register per pulse
	assign bus.wr_sel  = (access && i_pwrite && !bad_addr) ? (reg_sel_t'(1) << word_idx) : '0;
	assign bus.wr_data = i_pwdata;

	always_comb
	begin
		case (word_idx)
			3'(RTC_REG_CLOCK):     o_prdata = bus.clock_rd;
			3'(RTC_REG_TIMER):     o_prdata = bus.timer_rd;
			3'(RTC_REG_STOPWATCH): o_prdata = bus.sw_rd;
			3'(RTC_REG_ALARM):     o_prdata = bus.alarm_rd;
			3'(RTC_REG_SPEED):     o_prdata = bus.speed_rd;
			default:               o_prdata = '0;
		endcase
	end

	assign o_interrupt = i_tmr_int || i_al_int;

	// Master side of the protocol: access only inside a selected transfer
	a_penable_psel: assert property (@(posedge i_clk) disable iff (i_rst)
		i_penable |-> i_psel);

endmodule

//--- source/rtc_tick_gen.sv
`timescale 1ns/1ps

module rtc_tick_gen #(
	parameter rtc_pkg::speed_t DEFAULT_SPEED = 32'd2814750
) (
	input  logic         i_clk,
	input  logic         i_rst,
	rtc_reg_if.speed_mp  bus,
	output logic         o_sub_tick
);
	import rtc_pkg::*;

	speed_t      speed;
	logic [39:0] phase;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			speed <= DEFAULT_SPEED;
		else if (bus.wr_sel[RTC_REG_SPEED])
			speed <= bus.wr_data;
	end

	// Carry out of the accumulator is the sub-second tick
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			phase      <= '0;
			o_sub_tick <= 1'b0;
		end
		else
			{o_sub_tick, phase} <= {1'b0, phase} + {9'h000, speed};
	end

	assign bus.speed_rd = speed;

endmodule

//--- source/rtc_clock.sv
`timescale 1ns/1ps

module rtc_clock #(
	parameter int SUB_W = 8
) (
	input  logic          i_clk,
	input  logic          i_rst,
	rtc_reg_if.clock_mp   bus,
	input  logic          i_sub_tick,
	output rtc_pkg::tod_t o_time,
	output logic          o_pps,
	output logic          o_ppd
);
	import rtc_pkg::*;

	logic [SUB_W-1:0] ck_sub;
	tod_t             tod;
	tod_t             tod_wr;
	logic [7:0]       hr_next;
	logic             sec_wrap;
	logic             min_wrap;

	assign sec_wrap = (tod[7:0] == 8'h59);
	assign min_wrap = (tod[15:8] == 8'h59);
	assign hr_next  = bcd_inc({2'b00, tod[21:16]}, 8'h23);
	assign tod_wr   = tod_merge(tod, bus.wr_data);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			ck_sub <= '0;
			o_pps  <= 1'b0;
			tod    <= '0;
		end
		else
		begin
			if (i_sub_tick)
				ck_sub <= ck_sub + 1'b1;
			// Second ends on the tick that wraps the sub counter
			o_pps <= i_sub_tick && (&ck_sub);

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Cascaded BCD rollover
			if (o_pps)
			begin
				tod[7:0] <= bcd_inc(tod[7:0], 8'h59);
				if (sec_wrap)
					tod[15:8] <= bcd_inc(tod[15:8], 8'h59);
				if (sec_wrap && min_wrap)
					tod[21:16] <= hr_next[5:0];
			end

			if (bus.wr_sel[RTC_REG_CLOCK])
			begin
				tod <= tod_wr;
				if (bus.wr_data[7:0] == 8'h00)
					ck_sub <= '0;
			end
		end
	end

	assign o_ppd        = o_pps && (tod == 22'h235959);
	assign o_time       = tod;
	assign bus.clock_rd = {10'h000, tod};

	// Software writes must keep the time a legal BCD value
	a_tod_bcd: assert property (@(posedge i_clk) disable iff (i_rst)
		(tod[21:16] <= 6'h23) && (tod[19:16] <= 4'h9)
		&& (tod[15:12] <= 4'h9) && (tod[11:8] <= 4'h9)
		&& (tod[7:4] <= 4'h9) && (tod[3:0] <= 4'h9));

endmodule

//--- source/rtc_timer.sv
`timescale 1ns/1ps

module rtc_timer #(
	parameter int SUB_W = 8
) (
	input  logic         i_clk,
	input  logic         i_rst,
	rtc_reg_if.timer_mp  bus,
	input  logic         i_sub_tick,
	output logic         o_int
);
	import rtc_pkg::*;

	tmr_count_t       count;
	tmr_count_t       start;
	logic             run;
	logic             alarm;
	logic [SUB_W-1:0] tm_sub;
	logic             tm_pps;
	logic             wr;

	// Borrow runs across digits 9,5,9,5,9
	function automatic tmr_count_t bcd_dec(tmr_count_t v);
		tmr_count_t r;
		logic       borrow;
		r = v;
		borrow = 1'b1;
		for (int d = 0; d < 6; d++)
		begin
			if (borrow)
			begin
				if (v[d*4 +: 4] != 4'h0)
				begin
					r[d*4 +: 4] = v[d*4 +: 4] - 4'h1;
					borrow = 1'b0;
				end
				else
					r[d*4 +: 4] = (d % 2 == 1) ? 4'h5 : 4'h9;
			end
		end
		return r;
	endfunction

	assign wr = bus.wr_sel[RTC_REG_TIMER];

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			count  <= '0;
			start  <= '0;
			run    <= 1'b0;
			alarm  <= 1'b0;
			tm_sub <= '0;
			tm_pps <= 1'b0;
			o_int  <= 1'b0;
		end
		else
		begin
			o_int <= 1'b0;
			if (i_sub_tick)
				tm_sub <= tm_sub + 1'b1;
			tm_pps <= i_sub_tick && (&tm_sub);

			if (wr && run)
				run <= bus.wr_data[TMR_RUN_BIT];

			// Expiry wins over a write in the same cycle
			if (run && !alarm)
			begin
				if (count == '0)
				begin
					alarm <= 1'b1;
					run   <= 1'b0;
					o_int <= 1'b1;
				end
				else if (tm_pps)
					count <= bcd_dec(count);
			end

			if (wr && !run)
			begin
				run   <= bus.wr_data[TMR_RUN_BIT];
				alarm <= 1'b0;
				if (bus.wr_data[23:0] != 24'h000000)
				begin
					count  <= bus.wr_data[23:0];
					start  <= bus.wr_data[23:0];
					tm_sub <= '0;
				end
				else if (count == '0)
				begin
					count  <= start;
					tm_sub <= '0;
				end
			end
		end
	end

	always_comb
	begin
		bus.timer_rd                = '0;
		bus.timer_rd[23:0]          = count;
		bus.timer_rd[TMR_RUN_BIT]   = run;
		bus.timer_rd[TMR_ALARM_BIT] = alarm;
	end

endmodule

//--- source/rtc_stopwatch.sv
`timescale 1ns/1ps

module rtc_stopwatch #(
	parameter int SUB_W = 8
) (
	input  logic      i_clk,
	input  logic      i_rst,
	rtc_reg_if.sw_mp  bus,
	input  logic      i_sub_tick
);
	import rtc_pkg::*;

	logic [SUB_W-1:0] sw_sub;
	logic [SUB_W+6:0] frac_ext;
	logic             sw_pps;
	logic             run;
	logic             wr;
	logic             clr;
	logic [7:0]       hh;
	logic [7:0]       mm;
	logic [7:0]       ss;

	assign wr  = bus.wr_sel[RTC_REG_STOPWATCH];
	// Clear only when stopped or stopping
	assign clr = wr && bus.wr_data[SW_CLR_BIT] && (!run || !bus.wr_data[SW_RUN_BIT]);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			sw_sub <= '0;
			sw_pps <= 1'b0;
			run    <= 1'b0;
			hh     <= '0;
			mm     <= '0;
			ss     <= '0;
		end
		else
		begin
			if (run && i_sub_tick)
				sw_sub <= sw_sub + 1'b1;
			sw_pps <= run && i_sub_tick && (&sw_sub);

			if (sw_pps)
			begin
				ss <= bcd_inc(ss, 8'h59);
				if (ss == 8'h59)
					mm <= bcd_inc(mm, 8'h59);
				if ((ss == 8'h59) && (mm == 8'h59))
					hh <= bcd_inc(hh, 8'h99);
			end

			if (wr)
				run <= bus.wr_data[SW_RUN_BIT];
			if (clr)
			begin
				sw_sub <= '0;
				sw_pps <= 1'b0;
				hh     <= '0;
				mm     <= '0;
				ss     <= '0;
			end
		end
	end

	// Top 7 fraction bits, zero filled for short counters
	assign frac_ext  = {sw_sub, 7'h00};
	assign bus.sw_rd = {hh, mm, ss, frac_ext[SUB_W+6 -: 7], run};

endmodule

//--- source/rtc_alarm.sv
`timescale 1ns/1ps

module rtc_alarm (
	input  logic          i_clk,
	input  logic          i_rst,
	rtc_reg_if.alarm_mp   bus,
	input  rtc_pkg::tod_t i_time,
	output logic          o_int
);
	import rtc_pkg::*;

	tod_t al_time;
	tod_t last_time;
	logic al_en;
	logic al_tripped;
	logic wr;
	logic hit;

	assign wr  = bus.wr_sel[RTC_REG_ALARM];
	// First cycle of a match only
	assign hit = al_en && (i_time == al_time) && (last_time != al_time);

	always_ff @(posedge i_clk)
		last_time <= i_time;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			al_time    <= '0;
			al_en      <= 1'b0;
			al_tripped <= 1'b0;
			o_int      <= 1'b0;
		end
		else
		begin
			o_int <= hit;
			if (wr)
			begin
				al_time <= tod_merge(al_time, bus.wr_data);
				al_en   <= bus.wr_data[AL_EN_BIT];
				if (bus.wr_data[AL_ACK_BIT] || !bus.wr_data[AL_EN_BIT])
					al_tripped <= 1'b0;
			end
			if (hit)
				al_tripped <= 1'b1;
		end
	end

	always_comb
	begin
		bus.alarm_rd             = '0;
		bus.alarm_rd[21:0]       = al_time;
		bus.alarm_rd[AL_EN_BIT]  = al_en;
		bus.alarm_rd[AL_ACK_BIT] = al_tripped;
	end

endmodule

//--- source/rtc_top.sv
`timescale 1ns/1ps

module rtc_top #(
	parameter rtc_pkg::speed_t DEFAULT_SPEED = 32'd2814750,
	parameter int              SUB_W         = 8
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_psel,
	input  logic               i_penable,
	input  logic               i_pwrite,
	input  logic [4:0]         i_paddr,
	input  rtc_pkg::rtc_word_t i_pwdata,
	output rtc_pkg::rtc_word_t o_prdata,
	output logic               o_pready,
	output logic               o_pslverr,
	output logic               o_interrupt,
	output logic               o_ppd
);
	import rtc_pkg::*;

	logic sub_tick;
	logic tmr_int;
	logic al_int;
	tod_t cur_time;

	rtc_reg_if bus ();

	rtc_apb_slave u_apb (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.bus(bus.host),
		.i_tmr_int(tmr_int), .i_al_int(al_int), .o_interrupt(o_interrupt)
	);

	rtc_tick_gen #(.DEFAULT_SPEED(DEFAULT_SPEED)) u_tick (
		.i_clk(i_clk), .i_rst(i_rst), .bus(bus.speed_mp), .o_sub_tick(sub_tick)
	);

	// Seconds pulse is only needed inside the clock
	rtc_clock #(.SUB_W(SUB_W)) u_clock (
		.i_clk(i_clk), .i_rst(i_rst), .bus(bus.clock_mp), .i_sub_tick(sub_tick),
		.o_time(cur_time), .o_pps(), .o_ppd(o_ppd)
	);

	rtc_timer #(.SUB_W(SUB_W)) u_timer (
		.i_clk(i_clk), .i_rst(i_rst), .bus(bus.timer_mp), .i_sub_tick(sub_tick),
		.o_int(tmr_int)
	);

	rtc_stopwatch #(.SUB_W(SUB_W)) u_sw (
		.i_clk(i_clk), .i_rst(i_rst), .bus(bus.sw_mp), .i_sub_tick(sub_tick)
	);

	rtc_alarm u_alarm (
		.i_clk(i_clk), .i_rst(i_rst), .bus(bus.alarm_mp), .i_time(cur_time),
		.o_int(al_int)
	);

endmodule

//--- verif/tb_rtc.sv
`timescale 1ns/1ps

module tb_rtc;
	import rtc_pkg::*;

	localparam int     HALF_PERIOD = 4;
	localparam speed_t RESET_SPEED = 32'h0100_0000;
	localparam int     MAX_ROWS    = 48;
	localparam int     EVENT_LIMIT = 20000;

	// Row operations
	localparam int OP_WRITE     = 0;
	localparam int OP_READ      = 1;
	localparam int OP_READ_NZ   = 2;
	localparam int OP_READ_SAME = 3;
	localparam int OP_EVENT     = 4;
	localparam int OP_CYCLES    = 5;

	logic       i_clk;
	logic       i_rst;
	logic       i_psel;
	logic       i_penable;
	logic       i_pwrite;
	logic [4:0] i_paddr;
	rtc_word_t  i_pwdata;
	rtc_word_t  o_prdata;
	logic       o_pready;
	logic       o_pslverr;
	logic       o_interrupt;
	logic       o_ppd;

	int         row_op [MAX_ROWS];
	int         row_test [MAX_ROWS];
	logic [2:0] row_idx [MAX_ROWS];
	rtc_word_t  row_data [MAX_ROWS];
	rtc_word_t  row_exp [MAX_ROWS];
	rtc_word_t  row_mask [MAX_ROWS];
	int         n_rows;
	logic       table_ready;
	string      test_name [1:5];
	logic [31:0] rng;
	int         pass_cnt;
	int         fail_cnt;

	rtc_top #(.DEFAULT_SPEED(RESET_SPEED), .SUB_W(2)) rtc_top_inst (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.o_interrupt(o_interrupt), .o_ppd(o_ppd)
	);

	always #HALF_PERIOD i_clk = ~i_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_word(input string name, input rtc_word_t exp, input rtc_word_t act);
		if (exp !== act)
		begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			fail_cnt++;
		end
		else
			pass_cnt++;
	endtask

	task automatic check_tod(input string name, input tod_t exp, input tod_t act);
		if (exp !== act)
		begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			fail_cnt++;
		end
		else
			pass_cnt++;
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			fail_cnt++;
		end
		else
			pass_cnt++;
	endtask

	task automatic add_row(input int op, input int test, input logic [2:0] idx,
			input rtc_word_t data, input rtc_word_t exp, input rtc_word_t mask);
		row_op[n_rows]   = op;
		row_test[n_rows] = test;
		row_idx[n_rows]  = idx;
		row_data[n_rows] = data;
		row_exp[n_rows]  = exp;
		row_mask[n_rows] = mask;
		n_rows++;
	endtask

	// Setup cycle, then one access cycle sampled away from the clock edges
	task automatic apb_transfer(input logic write, input logic [2:0] idx,
			input rtc_word_t wdata, output rtc_word_t rdata);
		@(negedge i_clk);
		i_psel    = 1'b1;
		i_penable = 1'b0;
		i_pwrite  = write;
		i_paddr   = {idx, 2'b00};
		i_pwdata  = wdata;
		@(negedge i_clk);
		i_penable = 1'b1;
		#1;
		rdata = o_prdata;
		check_flag("o_pready", 1'b1, o_pready);
		check_flag("o_pslverr", idx > 3'd4, o_pslverr);
		@(negedge i_clk);
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
	endtask

	// want bit 0 is o_interrupt, bit 1 is o_ppd
	task automatic wait_event(input logic [1:0] want);
		int n;
		n = 0;
		while (!(o_interrupt || o_ppd) && n < EVENT_LIMIT)
		begin
			@(negedge i_clk);
			n++;
		end
		if (n >= EVENT_LIMIT)
		begin
			$display("Neither o_interrupt nor o_ppd went high within %0d cycles", EVENT_LIMIT);
			fail_cnt++;
		end
		else
		begin
			if (want[0])
				check_flag("o_interrupt", 1'b1, o_interrupt);
			if (want[1])
				check_flag("o_ppd", 1'b1, o_ppd);
		end
		@(negedge i_clk);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic build_table();
		rtc_word_t  junk;
		tmr_count_t tmr_start;
		rng       = xorshift(rng);
		// Run bit set so a stray stopwatch write would show up
		junk      = rng | 32'h0000_0001;
		rng       = xorshift(rng);
		tmr_start = tmr_count_t'((rng % 3) + 1);
		for (int r = 0; r < 4; r++)
			add_row(OP_READ, 1, 3'(r), '0, '0, '1);
		add_row(OP_READ, 1, 3'd4, '0, RESET_SPEED, '1);
		add_row(OP_READ, 1, 3'd5, '0, '0, '1);
		add_row(OP_WRITE, 1, 3'd6, junk, '0, '0);
		for (int r = 0; r < 4; r++)
			add_row(OP_READ, 1, 3'(r), '0, '0, '1);
		add_row(OP_READ, 1, 3'd4, '0, RESET_SPEED, '1);
		// Roughly 1024 clocks per second from here on
		add_row(OP_WRITE, 1, 3'd4, 32'hffff_ffff, '0, '0);
		add_row(OP_READ, 1, 3'd4, '0, 32'hffff_ffff, '1);
		add_row(OP_WRITE, 2, 3'd0, 32'h0023_5958, '0, '0);
		add_row(OP_WRITE, 2, 3'd0, 32'h0023_ff58, '0, '0);
		add_row(OP_READ, 2, 3'd0, '0, 32'h0023_5950, 32'hffff_fff0);
		add_row(OP_EVENT, 2, 3'd0, '0, '0, 32'h2);
		add_row(OP_READ, 2, 3'd0, '0, '0, 32'hffff_fff0);
		add_row(OP_WRITE, 3, 3'd1, 32'h0100_0000 | tmr_start, '0, '0);
		add_row(OP_EVENT, 3, 3'd1, '0, '0, 32'h1);
		add_row(OP_READ, 3, 3'd1, '0, 32'h0200_0000, '1);
		add_row(OP_WRITE, 3, 3'd1, 32'h0100_0000, '0, '0);
		add_row(OP_READ, 3, 3'd1, '0, 32'h0100_0000 | tmr_start, '1);
		// Count field is ignored while running
		add_row(OP_WRITE, 3, 3'd1, 32'h0000_0009, '0, '0);
		add_row(OP_READ, 3, 3'd1, '0, {8'h00, tmr_start}, '1);
		add_row(OP_WRITE, 4, 3'd2, 32'h1, '0, '0);
		add_row(OP_CYCLES, 4, 3'd2, 32'd3000, '0, '0);
		add_row(OP_WRITE, 4, 3'd2, 32'h0, '0, '0);
		add_row(OP_READ_NZ, 4, 3'd2, '0, '0, 32'h0000_ff00);
		add_row(OP_CYCLES, 4, 3'd2, 32'd500, '0, '0);
		add_row(OP_READ_SAME, 4, 3'd2, '0, '0, '1);
		add_row(OP_WRITE, 4, 3'd2, 32'h2, '0, '0);
		add_row(OP_READ, 4, 3'd2, '0, '0, '1);
		add_row(OP_WRITE, 5, 3'd0, 32'h0010_0000, '0, '0);
		add_row(OP_WRITE, 5, 3'd3, 32'h0110_0002, '0, '0);
		add_row(OP_EVENT, 5, 3'd3, '0, '0, 32'h1);
		add_row(OP_READ, 5, 3'd3, '0, 32'h0310_0002, '1);
		add_row(OP_WRITE, 5, 3'd3, 32'h0310_0002, '0, '0);
		add_row(OP_READ, 5, 3'd3, '0, 32'h0110_0002, '1);
	endtask

	initial
	begin
		wait (table_ready);
		repeat (n_rows * 20000) @(posedge i_clk);
		$display("Run timed out after %0d clocks with tests still running", n_rows * 20000);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		rtc_word_t rdata;
		rtc_word_t held;
		int        fails_at_start;
		i_clk       = 1'b0;
		i_rst       = 1'b1;
		i_psel      = 1'b0;
		i_penable   = 1'b0;
		i_pwrite    = 1'b0;
		i_paddr     = '0;
		i_pwdata    = '0;
		rng         = 32'had5b;
		n_rows      = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		held        = '0;
		test_name[1] = "reset state and errors";
		test_name[2] = "clock set and day rollover";
		test_name[3] = "timer countdown and reload";
		test_name[4] = "stopwatch";
		test_name[5] = "alarm";
		build_table();
		table_ready = 1'b1;
		repeat (16) @(negedge i_clk);
		i_rst = 1'b0;
		fails_at_start = 0;

		for (int i = 0; i < n_rows; i++)
		begin
			case (row_op[i])
				OP_WRITE:
					apb_transfer(1'b1, row_idx[i], row_data[i], rdata);
				OP_READ:
				begin
					apb_transfer(1'b0, row_idx[i], '0, rdata);
					if (row_idx[i] == 3'(RTC_REG_CLOCK))
						check_tod("o_prdata time", tod_t'(row_exp[i] & row_mask[i]),
							tod_t'(rdata & row_mask[i]));
					else
						check_word($sformatf("o_prdata reg %0d", row_idx[i]),
							row_exp[i] & row_mask[i], rdata & row_mask[i]);
				end
				OP_READ_NZ:
				begin
					apb_transfer(1'b0, row_idx[i], '0, rdata);
					check_flag("stopwatch seconds nonzero", 1'b1, |(rdata & row_mask[i]));
					held = rdata;
				end
				OP_READ_SAME:
				begin
					apb_transfer(1'b0, row_idx[i], '0, rdata);
					check_word("o_prdata held", held, rdata);
				end
				OP_EVENT:
					wait_event(row_mask[i][1:0]);
				default:
					repeat (row_data[i]) @(negedge i_clk);
			endcase

			if (i == n_rows - 1 || row_test[i + 1] != row_test[i])
			begin
				$display("Test %0d %s: %s", row_test[i], test_name[row_test[i]],
					(fail_cnt == fails_at_start) ? "ok" : "failed");
				fails_at_start = fail_cnt;
			end
		end

		$display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- sources.f
source/rtc_pkg.sv
source/rtc_reg_if.sv
source/rtc_apb_slave.sv
source/rtc_tick_gen.sv
source/rtc_clock.sv
source/rtc_timer.sv
source/rtc_stopwatch.sv
source/rtc_alarm.sv
source/rtc_top.sv
verif/tb_rtc.sv
